// ==== design/axil_slave_port.sv ====
// AXI4-Lite slave port
`timescale 1ns/1ps

module axil_slave_port (
    input  logic                clk,
    input  logic                rst_n,

    // Write address channel
    input  rng_pkg::axil_addr_t s_axi_awaddr,
    input  logic                s_axi_awvalid,
    output logic                s_axi_awready,

    // Write data channel
    input  rng_pkg::axil_data_t s_axi_wdata,
    input  rng_pkg::axil_strb_t s_axi_wstrb,
    input  logic                s_axi_wvalid,
    output logic                s_axi_wready,

    // Write response channel
    output rng_pkg::axil_resp_t s_axi_bresp,
    output logic                s_axi_bvalid,
    input  logic                s_axi_bready,

    // Read address channel
    input  rng_pkg::axil_addr_t s_axi_araddr,
    input  logic                s_axi_arvalid,
    output logic                s_axi_arready,

    // Read data channel
    output rng_pkg::axil_data_t s_axi_rdata,
    output rng_pkg::axil_resp_t s_axi_rresp,
    output logic                s_axi_rvalid,
    input  logic                s_axi_rready,

    // Register block side
    output logic                wr_en,
    output rng_pkg::axil_addr_t wr_addr,
    output rng_pkg::axil_data_t wr_data,
    output rng_pkg::axil_strb_t wr_strb,
    output rng_pkg::axil_addr_t rd_addr,
    input  rng_pkg::axil_data_t rd_data
);

    import rng_pkg::*;

    logic       awready_q;
    logic       wready_q;
    logic       bvalid_q;
    axil_resp_t bresp_q;
    logic       arready_q;
    logic       rvalid_q;
    axil_resp_t rresp_q;
    axil_data_t rdata_q;

    logic       wr_accept;
    logic       rd_accept;

    // Both write channels must be present and the last response retired
    assign wr_accept = s_axi_awvalid & s_axi_wvalid & ~bvalid_q & ~awready_q & ~wready_q;
    assign rd_accept = s_axi_arvalid & ~arready_q & ~rvalid_q;

    // AW and W readies pulse together for one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
        end else begin
            awready_q <= wr_accept;
            wready_q  <= wr_accept;
        end
    end

    // Write strobe to the registers during the ready cycle
    assign wr_en   = awready_q & wready_q & s_axi_awvalid & s_axi_wvalid;
    assign wr_addr = s_axi_awaddr;
    assign wr_data = s_axi_wdata;
    assign wr_strb = s_axi_wstrb;

    // Response raised on the edge where the register update lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
        end else if (wr_en && !bvalid_q) begin
            bvalid_q <= 1'b1;
            bresp_q  <= RESP_OKAY;
        end else if (bvalid_q && s_axi_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready_q <= 1'b0;
        end else begin
            arready_q <= rd_accept;
        end
    end

    // Address goes straight to the read mux
    assign rd_addr = s_axi_araddr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            rresp_q  <= RESP_OKAY;
        end else if (arready_q && s_axi_arvalid && !rvalid_q) begin
            rvalid_q <= 1'b1;
            rresp_q  <= RESP_OKAY;
        end else if (rvalid_q && s_axi_rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Read data captured once per transfer and held until taken
    always_ff @(posedge clk) begin
        if (arready_q && s_axi_arvalid && !rvalid_q) begin
            rdata_q <= rd_data;
        end
    end

    assign s_axi_awready = awready_q;
    assign s_axi_wready  = wready_q;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_bresp   = bresp_q;
    assign s_axi_arready = arready_q;
    assign s_axi_rvalid  = rvalid_q;
    assign s_axi_rresp   = rresp_q;
    assign s_axi_rdata   = rdata_q;

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
    );

    a_rdata_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
    );

    // Back-pressure on B must stall the address and data channels
    a_no_accept_during_b: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_axi_bvalid |-> !s_axi_awready && !s_axi_wready
    );

endmodule

// ==== design/lfsr_core.sv ====
// Four-bit Fibonacci LFSR
`timescale 1ns/1ps
`include "rng_defs.svh"

module lfsr_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lfsr_load,
    input  rng_pkg::lfsr_state_t lfsr_seed,
    input  logic                 lfsr_step,
    output rng_pkg::lfsr_state_t lfsr_state
);

    import rng_pkg::*;

    lfsr_state_t state_q;
    logic        feedback;

    // Taps for x^4 + x^3 + 1
    assign feedback = state_q[`LFSR_W-1] ^ state_q[`LFSR_W-2];

    // Load wins over a step in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= `RNG_RESET_SEED;
        end else if (lfsr_load) begin
            state_q <= lfsr_seed;
        end else if (lfsr_step) begin
            state_q <= {state_q[`LFSR_W-2:0], feedback};
        end
    end

    assign lfsr_state = state_q;

    // Zero is the one state the shift can never leave
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        state_q != '0
    );

    a_seed_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        lfsr_load |-> lfsr_seed != '0
    );

endmodule

// ==== design/rng_lfsr_axil_top.sv ====
// LFSR random number peripheral top
`timescale 1ns/1ps

module rng_lfsr_axil_top (
    input  logic                clk,
    input  logic                rst_n,

    input  rng_pkg::axil_addr_t s_axi_awaddr,
    input  logic                s_axi_awvalid,
    output logic                s_axi_awready,

    input  rng_pkg::axil_data_t s_axi_wdata,
    input  rng_pkg::axil_strb_t s_axi_wstrb,
    input  logic                s_axi_wvalid,
    output logic                s_axi_wready,

    output rng_pkg::axil_resp_t s_axi_bresp,
    output logic                s_axi_bvalid,
    input  logic                s_axi_bready,

    input  rng_pkg::axil_addr_t s_axi_araddr,
    input  logic                s_axi_arvalid,
    output logic                s_axi_arready,

    output rng_pkg::axil_data_t s_axi_rdata,
    output rng_pkg::axil_resp_t s_axi_rresp,
    output logic                s_axi_rvalid,
    input  logic                s_axi_rready
);

    import rng_pkg::*;

    // Port to register block
    logic        wr_en;
    axil_addr_t  wr_addr;
    axil_data_t  wr_data;
    axil_strb_t  wr_strb;
    axil_addr_t  rd_addr;
    axil_data_t  rd_data;

    // Register block to generator
    logic        lfsr_load;
    lfsr_state_t lfsr_seed;
    logic        lfsr_step;
    lfsr_state_t lfsr_state;

    axil_slave_port u_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    rng_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .lfsr_state (lfsr_state),
        .lfsr_load  (lfsr_load),
        .lfsr_seed  (lfsr_seed),
        .lfsr_step  (lfsr_step)
    );

    lfsr_core u_lfsr (
        .clk        (clk),
        .rst_n      (rst_n),
        .lfsr_load  (lfsr_load),
        .lfsr_seed  (lfsr_seed),
        .lfsr_step  (lfsr_step),
        .lfsr_state (lfsr_state)
    );

endmodule

// ==== design/rng_pkg.sv ====
// RNG peripheral types
`include "rng_defs.svh"

package rng_pkg;

    // AXI4-Lite fields
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;

    // Response codes, the peripheral only ever answers OKAY
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Generator state
    typedef logic [`LFSR_W-1:0] lfsr_state_t;

endpackage

// ==== design/rng_regs.sv ====
// RNG register map
`timescale 1ns/1ps
`include "rng_defs.svh"

module rng_regs (
    input  logic                 clk,
    input  logic                 rst_n,

    // Access from the bus port
    input  logic                 wr_en,
    input  rng_pkg::axil_addr_t  wr_addr,
    input  rng_pkg::axil_data_t  wr_data,
    input  rng_pkg::axil_strb_t  wr_strb,
    input  rng_pkg::axil_addr_t  rd_addr,
    output rng_pkg::axil_data_t  rd_data,

    // Generator control
    input  rng_pkg::lfsr_state_t lfsr_state,
    output logic                 lfsr_load,
    output rng_pkg::lfsr_state_t lfsr_seed,
    output logic                 lfsr_step
);

    import rng_pkg::*;

    logic        lane0_wr;
    logic        ctrl_wr;
    logic        seed_wr;
    logic        single_step;
    logic        enable_q;
    lfsr_state_t seed_field;

    // Only the low byte carries register bits
    assign lane0_wr = wr_en & wr_strb[0];
    assign ctrl_wr  = lane0_wr && (wr_addr == `RNG_ADDR_CTRL);
    assign seed_wr  = lane0_wr && (wr_addr == `RNG_ADDR_SEED);

    // Free-running enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
        end else if (ctrl_wr) begin
            enable_q <= wr_data[`RNG_CTRL_ENABLE];
        end
    end

    // Step bit is a command and is never stored
    assign single_step = ctrl_wr & wr_data[`RNG_CTRL_STEP];
    assign lfsr_step   = enable_q | single_step;

    // An all-zero seed would lock up the generator
    assign seed_field = wr_data[`LFSR_W-1:0];
    assign lfsr_load  = seed_wr;
    assign lfsr_seed  = (seed_field == '0) ? `RNG_RESET_SEED : seed_field;

    // Read mux, SEED is write-only and reads as zero
    always_comb begin
        rd_data = '0;
        case (rd_addr)
            `RNG_ADDR_CTRL: rd_data[`RNG_CTRL_ENABLE] = enable_q;
            `RNG_ADDR_RAND: rd_data[`LFSR_W-1:0] = lfsr_state;
            default: rd_data = '0;
        endcase
    end

    a_load_step_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(lfsr_load && single_step)
    );

endmodule

// ==== filelist.f ====
+incdir+include
design/rng_pkg.sv
design/axil_slave_port.sv
design/rng_regs.sv
design/lfsr_core.sv
design/rng_lfsr_axil_top.sv
sim/tb_clock_gen.sv
sim/tb_rng_lfsr_axil.sv

// ==== include/rng_defs.svh ====
// RNG peripheral definitions
`ifndef RNG_DEFS_SVH
`define RNG_DEFS_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Generator width and the state after reset
`define LFSR_W 4
`define RNG_RESET_SEED 4'b1010

// Register map
`define RNG_ADDR_CTRL 4'h0
`define RNG_ADDR_RAND 4'h4
`define RNG_ADDR_SEED 4'h8

// CTRL register bits
`define RNG_CTRL_ENABLE 0
`define RNG_CTRL_STEP 1

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the RNG peripheral testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_rng_lfsr_axil -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$log_file"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Held over two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== sim/tb_rng_lfsr_axil.sv ====
// LFSR peripheral testbench
`timescale 1ns/1ps
`include "rng_defs.svh"

module tb_rng_lfsr_axil;

    import rng_pkg::*;

    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst_n;
    axil_addr_t  s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    axil_data_t  s_axi_wdata;
    axil_strb_t  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    axil_resp_t  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    axil_addr_t  s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    axil_data_t  s_axi_rdata;
    axil_resp_t  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    integer      seed;
    axil_data_t  exp_q[$];
    axil_data_t  act_q[$];
    axil_resp_t  bresp_log[$];
    axil_resp_t  rresp_log[$];

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rng_lfsr_axil_top dut (.*);

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // x^4 + x^3 + 1, shifted left with bit 3 XOR bit 2 entering at bit 0
    function automatic lfsr_state_t lfsr_next(input lfsr_state_t s);
        return {s[2:0], s[3] ^ s[2]};
    endfunction

    function automatic lfsr_state_t lfsr_advance(input lfsr_state_t s, input int k);
        lfsr_state_t r;
        r = s;
        for (int i = 0; i < k; i++) begin
            r = lfsr_next(r);
        end
        return r;
    endfunction

    function automatic int pick_stall();
        return $unsigned($random(seed)) % 6;
    endfunction

    // Presents AW and W together and holds them across the accepting edge
    task automatic write_request(input axil_addr_t addr, input axil_data_t data,
                                 input axil_strb_t strb);
        int n;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("write address and data channels never became ready");
            end
        end while (!(s_axi_awready && s_axi_wready));
        @(negedge clk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
    endtask

    task automatic write_response(input int stall);
        int n;
        n = 0;
        while (!s_axi_bvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("write response channel never became valid");
            end
        end
        // B held back, so no new write may get in
        repeat (stall) begin
            @(negedge clk);
            if (!s_axi_bvalid || s_axi_awready || s_axi_wready) begin
                abort_run("write response dropped or new write accepted under back-pressure");
            end
        end
        bresp_log.push_back(s_axi_bresp);
        s_axi_bready = 1'b1;
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input int stall);
        write_request(addr, data, strb);
        write_response(stall);
    endtask

    // Presents AR and holds it across the accepting edge
    task automatic read_request(input axil_addr_t addr);
        int n;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("read address channel never became ready");
            end
        end while (!s_axi_arready);
        @(negedge clk);
        s_axi_arvalid = 1'b0;
    endtask

    task automatic read_response(input int stall, input bit track, output axil_data_t data);
        int n;
        n = 0;
        while (!s_axi_rvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("read data channel never became valid");
            end
        end
        data = s_axi_rdata;
        // R held back, so no new read may get in
        repeat (stall) begin
            @(negedge clk);
            if (!s_axi_rvalid || s_axi_arready) begin
                abort_run("read data dropped or new read accepted under back-pressure");
            end
            check_data("s_axi_rdata", data, s_axi_rdata);
        end
        if (track) begin
            act_q.push_back(data);
        end
        rresp_log.push_back(s_axi_rresp);
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, input int stall, input bit track,
                             output axil_data_t data);
        read_request(addr);
        read_response(stall, track, data);
    endtask

    task automatic expect_read(input axil_addr_t addr, input axil_data_t exp, input int stall);
        axil_data_t dummy;
        exp_q.push_back(exp);
        axil_read(addr, stall, 1'b1, dummy);
    endtask

    // Matches tracked reads to the model in order, and every response to OKAY
    always @(negedge clk) begin
        while (exp_q.size() > 0 && act_q.size() > 0) begin
            check_data("s_axi_rdata", exp_q.pop_front(), act_q.pop_front());
        end
        while (bresp_log.size() > 0) begin
            check_resp("s_axi_bresp", RESP_OKAY, bresp_log.pop_front());
        end
        while (rresp_log.size() > 0) begin
            check_resp("s_axi_rresp", RESP_OKAY, rresp_log.pop_front());
        end
    end

    initial begin
        axil_data_t  val;
        axil_data_t  rd;
        lfsr_state_t st;
        int          k;
        int          n;
        seed          = 32'h7043e783;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("reset was never released");
            end
        end
        @(negedge clk);

        // Reset state
        expect_read(`RNG_ADDR_CTRL, 32'h0, 0);
        expect_read(`RNG_ADDR_RAND, 32'hA, 0);

        // Seed loads with random B and R back-pressure
        for (int i = 0; i < 4; i++) begin
            val = $random(seed);
            st = val[3:0];
            if (st == 4'h0) begin
                st = 4'h9;
            end
            axil_write(`RNG_ADDR_SEED, axil_data_t'(st), 4'hF, pick_stall());
            expect_read(`RNG_ADDR_RAND, axil_data_t'(st), pick_stall());
        end
        axil_write(`RNG_ADDR_SEED, 32'h0, 4'hF, 0);
        expect_read(`RNG_ADDR_RAND, 32'hA, 0);
        // Lane 0 not strobed, so the seed is ignored
        axil_write(`RNG_ADDR_SEED, 32'h3, 4'hE, 0);
        expect_read(`RNG_ADDR_RAND, 32'hA, 0);

        // Single steps
        for (int t = 0; t < 3; t++) begin
            val = $random(seed);
            st = val[3:0];
            if (st == 4'h0) begin
                st = 4'h3;
            end
            axil_write(`RNG_ADDR_SEED, axil_data_t'(st), 4'h1, 0);
            k = $unsigned($random(seed)) % 20 + 1;
            repeat (k) begin
                axil_write(`RNG_ADDR_CTRL, 32'h2, 4'h1, pick_stall());
            end
            expect_read(`RNG_ADDR_RAND, axil_data_t'(lfsr_advance(st, k)), pick_stall());
            expect_read(`RNG_ADDR_CTRL, 32'h0, 0);
        end

        // Free running, then stopped
        axil_write(`RNG_ADDR_CTRL, 32'h1, 4'h1, 0);
        expect_read(`RNG_ADDR_CTRL, 32'h1, 0);
        axil_write(`RNG_ADDR_CTRL, 32'h0, 4'h1, 0);
        axil_read(`RNG_ADDR_RAND, 0, 1'b0, rd);
        if (rd == '0) begin
            abort_run("generator state read as zero after free running");
        end
        expect_read(`RNG_ADDR_RAND, rd, pick_stall());
        axil_write(`RNG_ADDR_CTRL, 32'h2, 4'h1, 0);
        expect_read(`RNG_ADDR_RAND, axil_data_t'(lfsr_next(rd[3:0])), 0);

        // Unmapped and write-only addresses
        expect_read(4'hC, 32'h0, 0);
        expect_read(`RNG_ADDR_SEED, 32'h0, 0);

        // Next write waits on the bus while the first response is stalled
        val = $random(seed);
        st = val[3:0];
        if (st == 4'h0) begin
            st = 4'h6;
        end
        write_request(`RNG_ADDR_SEED, 32'h5, 4'h1);
        s_axi_awaddr  = `RNG_ADDR_SEED;
        s_axi_wdata   = axil_data_t'(st);
        s_axi_wstrb   = 4'h1;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        write_response(pick_stall() + 1);
        write_request(`RNG_ADDR_SEED, axil_data_t'(st), 4'h1);
        write_response(pick_stall());

        // Next read waits on the bus while the first data is stalled
        exp_q.push_back(axil_data_t'(st));
        read_request(`RNG_ADDR_RAND);
        s_axi_araddr  = `RNG_ADDR_CTRL;
        s_axi_arvalid = 1'b1;
        read_response(pick_stall() + 2, 1'b1, rd);
        exp_q.push_back(32'h0);
        read_request(`RNG_ADDR_CTRL);
        read_response(pick_stall(), 1'b1, rd);

        n = 0;
        while (exp_q.size() > 0 || act_q.size() > 0 ||
               bresp_log.size() > 0 || rresp_log.size() > 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("reads or responses were left without a comparison");
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
